// File: include/bridge_defs.svh
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// byte address, same width on the requester and AXI sides
`define BRIDGE_ADDR_BITS 32

// one cache line per transfer
`define BRIDGE_LINE_BITS 128

// AXI data bus width
`define BRIDGE_BEAT_BITS 32

// beats per line, LINE_BITS / BEAT_BITS
`define BRIDGE_BEATS 4

// counter wide enough to index every beat of a line
`define BRIDGE_BEAT_IDX_BITS 2

`endif

// File: hw/bridge_pkg.sv
`default_nettype none

`include "bridge_defs.svh"

package bridge_pkg;

    // one requester port, a full line in each direction
    typedef struct packed {
        logic                           we;
        logic [`BRIDGE_ADDR_BITS-1:0]   addr;
        logic [`BRIDGE_LINE_BITS-1:0]   wdata;
        // one bit per line byte
        logic [`BRIDGE_LINE_BITS/8-1:0] wmask;
    } sram_req_t;

    // which port a burst belongs to
    typedef enum logic {
        owner_data = 1'b0,
        owner_inst = 1'b1
    } owner_t;

    // read address channel
    typedef struct packed {
        logic [`BRIDGE_ADDR_BITS-1:0] addr;
        // beats minus one
        logic [7:0]                   len;
    } axi_ar_t;

    // write address channel, same layout as AR
    typedef struct packed {
        logic [`BRIDGE_ADDR_BITS-1:0] addr;
        logic [7:0]                   len;
    } axi_aw_t;

    // one read beat
    typedef struct packed {
        logic [`BRIDGE_BEAT_BITS-1:0] data;
        logic                         last;
    } axi_r_t;

    // one write beat
    typedef struct packed {
        logic [`BRIDGE_BEAT_BITS-1:0]   data;
        logic [`BRIDGE_BEAT_BITS/8-1:0] strb;
        logic                           last;
    } axi_w_t;

endpackage

`default_nettype wire

// File: hw/line_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module line_reader (
    input  logic                         aclk,
    input  logic                         reset,
    input  logic                         rd_start,
    input  logic [`BRIDGE_ADDR_BITS-1:0] rd_addr,
    output logic                         ar_valid,
    input  logic                         ar_ready,
    output bridge_pkg::axi_ar_t          ar,
    input  logic                         rd_valid,
    output logic                         rd_ready,
    input  bridge_pkg::axi_r_t           rd,
    output logic                         rd_busy,
    output logic                         rd_done,
    output logic [`BRIDGE_LINE_BITS-1:0] rd_line
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } state_t;

    state_t                           state;
    logic [`BRIDGE_BEAT_IDX_BITS-1:0] beat_idx;
    axi_ar_t                          ar_q;

    assign ar      = ar_q;
    assign rd_busy = (state != st_idle);

    // control FSM
    always_ff @(posedge aclk) begin
        if (!reset) begin
            state    <= st_idle;
            ar_valid <= 1'b0;
            rd_ready <= 1'b0;
            rd_done  <= 1'b0;
            beat_idx <= '0;
        end else begin
            // done is a single pulse
            rd_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (rd_start) begin
                        ar_valid <= 1'b1;
                        state    <= st_addr;
                    end
                end
                st_addr: begin
                    // hold AR until the slave takes it
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        rd_ready <= 1'b1;
                        beat_idx <= '0;
                        state    <= st_data;
                    end
                end
                st_data: begin
                    if (rd_valid && rd_ready) begin
                        beat_idx <= beat_idx + 1'b1;
                        // burst ends on last, counter is only for placement
                        if (rd.last) begin
                            rd_ready <= 1'b0;
                            rd_done  <= 1'b1;
                            state    <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address and assembled line
    always_ff @(posedge aclk) begin
        if (state == st_idle && rd_start) begin
            ar_q.addr <= rd_addr;
            ar_q.len  <= 8'(`BRIDGE_BEATS - 1);
        end
        // lowest beat lands in the low bits
        if (state == st_data && rd_valid && rd_ready) begin
            rd_line[beat_idx*`BRIDGE_BEAT_BITS +: `BRIDGE_BEAT_BITS] <= rd.data;
        end
    end

endmodule

`default_nettype wire

// File: hw/line_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module line_writer (
    input  logic                  aclk,
    input  logic                  reset,
    input  logic                  wr_start,
    input  bridge_pkg::sram_req_t wr_req,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output bridge_pkg::axi_aw_t   aw,
    output logic                  wd_valid,
    input  logic                  wd_ready,
    output bridge_pkg::axi_w_t    wd,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    output logic                  wr_busy,
    output logic                  wr_done
);
    import bridge_pkg::*;

    localparam int unsigned last_beat = `BRIDGE_BEATS - 1;

    typedef enum logic [1:0] {
        st_idle,
        st_send,
        st_resp
    } state_t;

    state_t                           state;
    logic [`BRIDGE_BEAT_IDX_BITS-1:0] beat;
    logic                             aw_sent;
    logic                             w_done;
    logic                             aw_fin;
    logic                             w_fin;
    axi_aw_t                          aw_q;
    logic [`BRIDGE_LINE_BITS-1:0]     data_buf;
    logic [`BRIDGE_LINE_BITS/8-1:0]   mask_buf;

    assign aw      = aw_q;
    assign wr_busy = (state != st_idle);

    // current beat sits in the low end of the shift buffers
    assign wd.data = data_buf[`BRIDGE_BEAT_BITS-1:0];
    assign wd.strb = mask_buf[`BRIDGE_BEAT_BITS/8-1:0];
    assign wd.last = (beat == last_beat);

    // address or data side finished, either earlier or this cycle
    assign aw_fin = aw_sent || (aw_valid && aw_ready);
    assign w_fin  = w_done || (wd_valid && wd_ready && wd.last);

    always_ff @(posedge aclk) begin
        if (!reset) begin
            state    <= st_idle;
            aw_valid <= 1'b0;
            wd_valid <= 1'b0;
            wr_ready <= 1'b0;
            wr_done  <= 1'b0;
            aw_sent  <= 1'b0;
            w_done   <= 1'b0;
            beat     <= '0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (wr_start) begin
                        aw_valid <= 1'b1;
                        wd_valid <= 1'b1;
                        aw_sent  <= 1'b0;
                        w_done   <= 1'b0;
                        beat     <= '0;
                        state    <= st_send;
                    end
                end
                st_send: begin
                    // AW and W run independently
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                        aw_sent  <= 1'b1;
                    end
                    if (wd_valid && wd_ready) begin
                        beat <= beat + 1'b1;
                        if (wd.last) begin
                            wd_valid <= 1'b0;
                            w_done   <= 1'b1;
                        end
                    end
                    // both sides through, open B
                    if (aw_fin && w_fin) begin
                        wr_ready <= 1'b1;
                        state    <= st_resp;
                    end
                end
                st_resp: begin
                    if (wr_valid && wr_ready) begin
                        wr_ready <= 1'b0;
                        wr_done  <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // line and mask, shifted down one beat per W transfer
    always_ff @(posedge aclk) begin
        if (state == st_idle && wr_start) begin
            aw_q.addr <= wr_req.addr;
            aw_q.len  <= 8'(`BRIDGE_BEATS - 1);
            data_buf  <= wr_req.wdata;
            mask_buf  <= wr_req.wmask;
        end else if (state == st_send && wd_valid && wd_ready) begin
            data_buf <= data_buf >> `BRIDGE_BEAT_BITS;
            mask_buf <= mask_buf >> (`BRIDGE_BEAT_BITS / 8);
        end
    end

endmodule

`default_nettype wire

// File: hw/port_steer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module port_steer (
    input  logic                         aclk,
    input  logic                         reset,
    input  logic                         inst_ce,
    input  bridge_pkg::sram_req_t        inst_req,
    input  logic                         data_ce,
    input  bridge_pkg::sram_req_t        data_req,
    input  logic                         rd_busy,
    input  logic                         rd_done,
    input  logic [`BRIDGE_LINE_BITS-1:0] rd_line,
    input  logic                         wr_busy,
    input  logic                         wr_done,
    output logic                         rd_start,
    output logic [`BRIDGE_ADDR_BITS-1:0] rd_addr,
    output logic                         wr_start,
    output bridge_pkg::sram_req_t        wr_req,
    output logic [`BRIDGE_LINE_BITS-1:0] inst_rdata,
    output logic                         inst_rdata_valid,
    output logic                         inst_write_finish,
    output logic [`BRIDGE_LINE_BITS-1:0] data_rdata,
    output logic                         data_rdata_valid,
    output logic                         data_write_finish
);
    import bridge_pkg::*;

    owner_t rd_owner;
    owner_t wr_owner;
    // port already in service, blocks a restart while ce is still high
    logic   inst_pend;
    logic   data_pend;
    logic   data_rd_req;
    logic   inst_rd_req;
    logic   data_wr_req;
    logic   inst_wr_req;

    // new requests per port and direction
    assign data_rd_req = data_ce && !data_pend && !data_req.we;
    assign inst_rd_req = inst_ce && !inst_pend && !inst_req.we;
    assign data_wr_req = data_ce && !data_pend && data_req.we;
    assign inst_wr_req = inst_ce && !inst_pend && inst_req.we;

    // write side, data first
    assign wr_start = !wr_busy && (data_wr_req || inst_wr_req);
    assign wr_req   = data_wr_req ? data_req : inst_req;

    // read side waits out any write, including one starting now
    assign rd_start = !rd_busy && !wr_busy && !wr_start && (data_rd_req || inst_rd_req);
    assign rd_addr  = data_rd_req ? data_req.addr : inst_req.addr;

    // completions go back to whoever owns the burst
    assign data_rdata_valid  = rd_done && (rd_owner == owner_data);
    assign inst_rdata_valid  = rd_done && (rd_owner == owner_inst);
    assign data_write_finish = wr_done && (wr_owner == owner_data);
    assign inst_write_finish = wr_done && (wr_owner == owner_inst);

    // line only means something during the valid pulse
    assign data_rdata = rd_line;
    assign inst_rdata = rd_line;

    always_ff @(posedge aclk) begin
        if (!reset) begin
            rd_owner  <= owner_data;
            wr_owner  <= owner_data;
            inst_pend <= 1'b0;
            data_pend <= 1'b0;
        end else begin
            if (rd_start) begin
                rd_owner <= data_rd_req ? owner_data : owner_inst;
            end
            if (wr_start) begin
                wr_owner <= data_wr_req ? owner_data : owner_inst;
            end
            // set on start, clear on the completion pulse
            if ((rd_start && data_rd_req) || (wr_start && data_wr_req)) begin
                data_pend <= 1'b1;
            end else if (data_rdata_valid || data_write_finish) begin
                data_pend <= 1'b0;
            end
            if ((rd_start && !data_rd_req) || (wr_start && !data_wr_req)) begin
                inst_pend <= 1'b1;
            end else if (inst_rdata_valid || inst_write_finish) begin
                inst_pend <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/sram_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module sram_axi_bridge (
    input  logic                         aclk,
    input  logic                         reset,
    // instruction port
    input  logic                         inst_ce,
    input  bridge_pkg::sram_req_t        inst_req,
    output logic [`BRIDGE_LINE_BITS-1:0] inst_rdata,
    output logic                         inst_rdata_valid,
    output logic                         inst_write_finish,
    // data port
    input  logic                         data_ce,
    input  bridge_pkg::sram_req_t        data_req,
    output logic [`BRIDGE_LINE_BITS-1:0] data_rdata,
    output logic                         data_rdata_valid,
    output logic                         data_write_finish,
    // AXI read
    output logic                         ar_valid,
    input  logic                         ar_ready,
    output bridge_pkg::axi_ar_t          ar,
    input  logic                         rd_valid,
    output logic                         rd_ready,
    input  bridge_pkg::axi_r_t           rd,
    // AXI write
    output logic                         aw_valid,
    input  logic                         aw_ready,
    output bridge_pkg::axi_aw_t          aw,
    output logic                         wd_valid,
    input  logic                         wd_ready,
    output bridge_pkg::axi_w_t           wd,
    input  logic                         wr_valid,
    output logic                         wr_ready
);
    import bridge_pkg::*;

    // steer to engine strobes
    logic                         rd_start;
    logic [`BRIDGE_ADDR_BITS-1:0] rd_addr;
    logic                         rd_busy;
    logic                         rd_done;
    logic [`BRIDGE_LINE_BITS-1:0] rd_line;
    logic                         wr_start;
    sram_req_t                    wr_req;
    logic                         wr_busy;
    logic                         wr_done;

    port_steer u_steer (
        .aclk              (aclk),
        .reset             (reset),
        .inst_ce           (inst_ce),
        .inst_req          (inst_req),
        .data_ce           (data_ce),
        .data_req          (data_req),
        .rd_busy           (rd_busy),
        .rd_done           (rd_done),
        .rd_line           (rd_line),
        .wr_busy           (wr_busy),
        .wr_done           (wr_done),
        .rd_start          (rd_start),
        .rd_addr           (rd_addr),
        .wr_start          (wr_start),
        .wr_req            (wr_req),
        .inst_rdata        (inst_rdata),
        .inst_rdata_valid  (inst_rdata_valid),
        .inst_write_finish (inst_write_finish),
        .data_rdata        (data_rdata),
        .data_rdata_valid  (data_rdata_valid),
        .data_write_finish (data_write_finish)
    );

    // AR and R
    line_reader u_reader (
        .aclk     (aclk),
        .reset    (reset),
        .rd_start (rd_start),
        .rd_addr  (rd_addr),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rd       (rd),
        .rd_busy  (rd_busy),
        .rd_done  (rd_done),
        .rd_line  (rd_line)
    );

    // AW, W and B
    line_writer u_writer (
        .aclk     (aclk),
        .reset    (reset),
        .wr_start (wr_start),
        .wr_req   (wr_req),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .wd_valid (wd_valid),
        .wd_ready (wd_ready),
        .wd       (wd),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_busy  (wr_busy),
        .wr_done  (wr_done)
    );

endmodule

`default_nettype wire

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module axi_mem_model (
    input  logic                aclk,
    input  logic                reset,
    input  logic                ar_valid,
    output logic                ar_ready,
    input  bridge_pkg::axi_ar_t ar,
    output logic                rd_valid,
    input  logic                rd_ready,
    output bridge_pkg::axi_r_t  rd,
    input  logic                aw_valid,
    output logic                aw_ready,
    input  bridge_pkg::axi_aw_t aw,
    input  logic                wd_valid,
    output logic                wd_ready,
    input  bridge_pkg::axi_w_t  wd,
    output logic                wr_valid,
    input  logic                wr_ready
);
    import bridge_pkg::*;

    // 1 KiB of words, index is addr[9:2]
    logic [`BRIDGE_BEAT_BITS-1:0]     mem [256];
    logic [31:0]                      rnd;
    // read burst in progress
    logic                             r_active;
    logic [7:0]                       r_idx;
    logic [7:0]                       r_left;
    // write side, W may arrive before AW
    logic                             aw_got;
    logic                             w_got;
    logic [7:0]                       w_base;
    logic [`BRIDGE_BEAT_IDX_BITS-1:0] w_cnt;
    logic [`BRIDGE_BEAT_BITS-1:0]     w_data [`BRIDGE_BEATS];
    logic [`BRIDGE_BEAT_BITS/8-1:0]   w_strb [`BRIDGE_BEATS];

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // every bit of the word index feeds the pattern
    function automatic logic [31:0] fill_word(input int unsigned i);
        return (i * 32'h9e3779b1) ^ 32'hc3a50f1e;
    endfunction

    always_ff @(posedge aclk) begin
        if (!reset) begin
            rnd      <= 32'h4ea8;
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            wd_ready <= 1'b0;
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
            rd       <= '0;
            r_active <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            w_cnt    <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(i);
            end
        end else begin
            rnd <= xorshift(rnd);
            // readies toggle at random, about half the time
            ar_ready <= rnd[0];
            aw_ready <= rnd[1];
            wd_ready <= rnd[2];
            if (ar_valid && ar_ready) begin
                r_active <= 1'b1;
                r_idx    <= ar.addr[9:2];
                r_left   <= ar.len;
            end
            // R beat held until taken
            if (rd_valid && rd_ready) begin
                rd_valid <= 1'b0;
                r_idx    <= r_idx + 1'b1;
                r_left   <= r_left - 1'b1;
                if (rd.last) begin
                    r_active <= 1'b0;
                end
            end else if (r_active && !rd_valid && rnd[3]) begin
                rd_valid <= 1'b1;
                rd.data  <= mem[r_idx];
                rd.last  <= (r_left == 8'd0);
            end
            if (aw_valid && aw_ready) begin
                aw_got <= 1'b1;
                w_base <= aw.addr[9:2];
            end
            if (wd_valid && wd_ready) begin
                w_data[w_cnt] <= wd.data;
                w_strb[w_cnt] <= wd.strb;
                w_cnt         <= w_cnt + 1'b1;
                if (wd.last) begin
                    w_got <= 1'b1;
                end
            end
            // commit bytes under strobe, then offer B
            if (aw_got && w_got && !wr_valid && rnd[4]) begin
                wr_valid <= 1'b1;
                for (int b = 0; b < `BRIDGE_BEATS; b++) begin
                    for (int k = 0; k < `BRIDGE_BEAT_BITS / 8; k++) begin
                        if (w_strb[b][k]) begin
                            mem[8'(w_base + b)][8*k +: 8] <= w_data[b][8*k +: 8];
                        end
                    end
                end
            end
            if (wr_valid && wr_ready) begin
                wr_valid <= 1'b0;
                aw_got   <= 1'b0;
                w_got    <= 1'b0;
                w_cnt    <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_sram_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bridge_defs.svh"

module tb_sram_axi_bridge;
    import bridge_pkg::*;

    localparam int n_rounds        = 6;
    localparam int n_tests         = 7 + n_rounds;
    localparam int watchdog_cycles = n_tests * (`BRIDGE_BEATS + 3) * 20;

    logic                         aclk;
    logic                         reset;
    logic                         inst_ce;
    logic                         data_ce;
    sram_req_t                    inst_req;
    sram_req_t                    data_req;
    logic [`BRIDGE_LINE_BITS-1:0] inst_rdata;
    logic [`BRIDGE_LINE_BITS-1:0] data_rdata;
    logic                         inst_rdata_valid;
    logic                         data_rdata_valid;
    logic                         inst_write_finish;
    logic                         data_write_finish;
    logic                         ar_valid;
    logic                         ar_ready;
    axi_ar_t                      ar;
    logic                         rd_valid;
    logic                         rd_ready;
    axi_r_t                       rd;
    logic                         aw_valid;
    logic                         aw_ready;
    axi_aw_t                      aw;
    logic                         wd_valid;
    logic                         wd_ready;
    axi_w_t                       wd;
    logic                         wr_valid;
    logic                         wr_ready;

    // reference memory, same fill as the slave
    logic [31:0] ref_mem [256];
    logic [31:0] rnd_state = 32'h4ea8;
    int          cycle = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          passed = 0;
    int          failed = 0;
    string       cur_test = "none";
    // previous-cycle copies for payload stability
    logic        ar_wait = 1'b0;
    logic        aw_wait = 1'b0;
    logic        wd_wait = 1'b0;
    axi_ar_t     ar_prev;
    axi_aw_t     aw_prev;
    axi_w_t      wd_prev;

    sram_axi_bridge DUT (.*);

    axi_mem_model slave (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] fill_word(input int unsigned i);
        return (i * 32'h9e3779b1) ^ 32'hc3a50f1e;
    endfunction

    // four words, lowest address in the low bits
    function automatic logic [127:0] ref_line(input logic [31:0] addr);
        logic [127:0] l;
        for (int b = 0; b < `BRIDGE_BEATS; b++) begin
            l[32*b +: 32] = ref_mem[addr[9:2] + b];
        end
        return l;
    endfunction

    // byte merge under wmask
    task automatic ref_write(input logic [31:0] addr, input logic [127:0] d,
                             input logic [15:0] m);
        for (int j = 0; j < 16; j++) begin
            if (m[j]) begin
                ref_mem[addr[9:2] + j / 4][8*(j % 4) +: 8] = d[8*j +: 8];
            end
        end
    endtask

    task automatic report_mismatch(input string what, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic check_eq(input string what, input logic [127:0] exp,
                            input logic [127:0] act);
        assert (act === exp) else report_mismatch(what, exp, act);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            passed++;
            $display("test %-20s pass", cur_test);
        end else begin
            failed++;
            $display("test %-20s FAIL", cur_test);
        end
    endtask

    task automatic random_line(output logic [127:0] d, output logic [15:0] m);
        for (int b = 0; b < `BRIDGE_BEATS; b++) begin
            rnd_state = xorshift(rnd_state);
            d[32*b +: 32] = rnd_state;
        end
        rnd_state = xorshift(rnd_state);
        m = rnd_state[15:0];
    endtask

    // hold ce and req until the pulse, drop ce the cycle after
    task automatic read_line(input bit on_data, input logic [31:0] addr,
                             output logic [127:0] line, output int stamp);
        sram_req_t r;
        r      = '0;
        r.addr = addr;
        @(posedge aclk);
        if (on_data) begin
            data_ce  <= 1'b1;
            data_req <= r;
        end else begin
            inst_ce  <= 1'b1;
            inst_req <= r;
        end
        @(negedge aclk);
        while (!(on_data ? data_rdata_valid : inst_rdata_valid)) @(negedge aclk);
        line  = on_data ? data_rdata : inst_rdata;
        stamp = cycle;
        @(posedge aclk);
        if (on_data) data_ce <= 1'b0;
        else inst_ce <= 1'b0;
    endtask

    task automatic write_line(input bit on_data, input logic [31:0] addr,
                              input logic [127:0] d, input logic [15:0] m,
                              output int stamp);
        sram_req_t r;
        r       = '0;
        r.we    = 1'b1;
        r.addr  = addr;
        r.wdata = d;
        r.wmask = m;
        @(posedge aclk);
        if (on_data) begin
            data_ce  <= 1'b1;
            data_req <= r;
        end else begin
            inst_ce  <= 1'b1;
            inst_req <= r;
        end
        @(negedge aclk);
        while (!(on_data ? data_write_finish : inst_write_finish)) @(negedge aclk);
        stamp = cycle;
        @(posedge aclk);
        if (on_data) data_ce <= 1'b0;
        else inst_ce <= 1'b0;
    endtask

    // write on one port, read the line back on another
    task automatic write_then_read(input string name, input bit wr_port, input bit rd_port,
                                   input logic [31:0] addr, input logic [127:0] d,
                                   input logic [15:0] m);
        logic [127:0] line;
        int           stamp;
        begin_test(name);
        ref_write(addr, d, m);
        write_line(wr_port, addr, d, m, stamp);
        read_line(rd_port, addr, line, stamp);
        check_eq("readback", ref_line(addr), line);
        end_test();
    endtask

    // valids stay up until their transfer
    ar_valid_held: assert property (@(posedge aclk) disable iff (!reset)
        ar_valid && !ar_ready |=> ar_valid)
        else report_mismatch("ar_valid held", 1, 0);
    aw_valid_held: assert property (@(posedge aclk) disable iff (!reset)
        aw_valid && !aw_ready |=> aw_valid)
        else report_mismatch("aw_valid held", 1, 0);
    wd_valid_held: assert property (@(posedge aclk) disable iff (!reset)
        wd_valid && !wd_ready |=> wd_valid)
        else report_mismatch("wd_valid held", 1, 0);

    // payload stability and completion routing, sampled before the edge updates
    always @(posedge aclk) begin
        if (reset) begin
            if (ar_wait) assert (ar == ar_prev) else report_mismatch("ar stable", ar_prev, ar);
            if (aw_wait) assert (aw == aw_prev) else report_mismatch("aw stable", aw_prev, aw);
            if (wd_wait) assert (wd == wd_prev) else report_mismatch("wd stable", wd_prev, wd);
            // write burst always covers one line
            if (aw_valid) assert (aw.len == 8'(`BRIDGE_BEATS - 1))
                else report_mismatch("aw len", `BRIDGE_BEATS - 1, aw.len);
            assert (!data_rdata_valid || (data_ce && !data_req.we))
                else report_mismatch("data_rdata_valid owner", 0, 1);
            assert (!inst_rdata_valid || (inst_ce && !inst_req.we))
                else report_mismatch("inst_rdata_valid owner", 0, 1);
            assert (!data_write_finish || (data_ce && data_req.we))
                else report_mismatch("data_write_finish owner", 0, 1);
            assert (!inst_write_finish || (inst_ce && inst_req.we))
                else report_mismatch("inst_write_finish owner", 0, 1);
        end
        ar_wait <= ar_valid && !ar_ready;
        aw_wait <= aw_valid && !aw_ready;
        wd_wait <= wd_valid && !wd_ready;
        ar_prev <= ar;
        aw_prev <= aw;
        wd_prev <= wd;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge aclk);
        $display("timeout: %0d tests not done after %0d cycles", n_tests, watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [127:0] dline;
        logic [127:0] iline;
        logic [127:0] d;
        logic [15:0]  m;
        logic [31:0]  addr;
        int           dstamp;
        int           istamp;
        int           wstamp;
        inst_ce  = 1'b0;
        data_ce  = 1'b0;
        inst_req = '0;
        data_req = '0;
        reset    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (2) @(posedge aclk);
        reset <= 1'b1;

        begin_test("reset_values");
        @(negedge aclk);
        check_eq("control outputs", 0, {ar_valid, aw_valid, wd_valid, rd_ready, wr_ready,
            inst_rdata_valid, data_rdata_valid, inst_write_finish, data_write_finish});
        end_test();

        begin_test("read_data_port");
        read_line(1'b1, 32'h040, dline, dstamp);
        check_eq("line", ref_line(32'h040), dline);
        end_test();

        begin_test("read_inst_port");
        read_line(1'b0, 32'h100, iline, istamp);
        check_eq("line", ref_line(32'h100), iline);
        end_test();

        write_then_read("masked_write_data", 1'b1, 1'b1, 32'h080,
            128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0, 16'ha5c3);
        write_then_read("masked_write_inst", 1'b0, 1'b1, 32'h0c0,
            128'h11223344_55667788_99aabbcc_ddeeff00, 16'h3c0f);

        // same-cycle reads, data port goes first
        begin_test("priority");
        fork
            read_line(1'b1, 32'h200, dline, dstamp);
            read_line(1'b0, 32'h240, iline, istamp);
        join
        check_eq("data line", ref_line(32'h200), dline);
        check_eq("inst line", ref_line(32'h240), iline);
        check_eq("data before inst", 1, dstamp < istamp);
        end_test();

        // inst read lands while the data write is busy
        begin_test("read_after_write");
        random_line(d, m);
        ref_write(32'h300, d, m);
        fork
            write_line(1'b1, 32'h300, d, m, wstamp);
            begin
                @(posedge aclk);
                read_line(1'b0, 32'h300, iline, istamp);
            end
        join
        check_eq("line", ref_line(32'h300), iline);
        check_eq("read after write", 1, istamp > wstamp);
        end_test();

        for (int r = 0; r < n_rounds; r++) begin
            random_line(d, m);
            rnd_state = xorshift(rnd_state);
            addr = rnd_state & 32'h3f0;
            write_then_read($sformatf("random_%0d", r), rnd_state[12], rnd_state[13],
                addr, d, m);
        end

        $display("tests: %0d passed, %0d failed, %0d check errors", passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hw/bridge_pkg.sv
hw/line_reader.sv
hw/line_writer.sv
hw/port_steer.sv
hw/sram_axi_bridge.sv
dv/axi_mem_model.sv
dv/tb_sram_axi_bridge.sv

// File: Bender.yml
package:
  name: sram_axi_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/bridge_pkg.sv
      - hw/line_reader.sv
      - hw/line_writer.sv
      - hw/port_steer.sv
      - hw/sram_axi_bridge.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/axi_mem_model.sv
      - dv/tb_sram_axi_bridge.sv
